//--- src.f
source/conv_pkg.sv
source/load_buffer.sv
source/stream_loader.sv
source/conv_window_mac.sv
source/conv_engine.sv
source/conv_top.sv
sim/conv_props.sv
sim/conv_tb.sv

//--- Makefile
# Verilator build and run of the convolution testbench

VERILATOR ?= verilator
TOP       ?= conv_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FAIL_MSG := FAIL: see errors above
PASS_MSG := PASS: all tests

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: build
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without completing"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/conv_tb.sv
module conv_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import conv_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 2;
    // beats over all tests: five kernel sets, eight images
    localparam int TOTAL_BEATS = 5 * KER_ENTRIES + 8 * IMG_ENTRIES;
    localparam int MARGIN_CYCLES = 400;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS + MARGIN_CYCLES;
    // cycles allowed between the last beat and its result
    localparam int RESULT_TIMEOUT = 20;

    logic        clk;
    logic        arst_n;
    logic        beat_valid;
    load_beat_t  beat;
    fmap_t       fmap;
    logic        fmap_valid;

    // beats waiting to be driven, results seen on fmap_valid
    load_beat_t  tx_q[$];
    fmap_t       res_q[$];
    // kernels currently held by the DUT
    kernel_set_t cur_ker;
    int          errors;
    int          err_mark;
    int          tests_run;
    int          tests_failed;

    conv_top i_conv_top (
        .clk        (clk),
        .arst_n     (arst_n),
        .beat_valid (beat_valid),
        .beat       (beat),
        .fmap       (fmap),
        .fmap_valid (fmap_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    // collect every result, sampled mid-cycle
    always @(negedge clk) begin
        if (arst_n && fmap_valid) begin
            res_q.push_back(fmap);
        end
    end

    function automatic pixel_t clamp_byte(int v);
        if (v > 127) begin
            return 8'sd127;
        end
        if (v < -128) begin
            return -8'sd128;
        end
        return pixel_t'(v);
    endfunction

    // valid 3x3 convolution, sum scaled down by 2**SHIFT
    function automatic fmap_t ref_fmap(image_t img, kernel_set_t ker);
        fmap_t m;
        int    acc;
        for (int d = 0; d < N_KERNELS; d++) begin
            for (int r = 0; r < OUT_DIM; r++) begin
                for (int c = 0; c < OUT_DIM; c++) begin
                    acc = 0;
                    for (int i = 0; i < K_DIM; i++) begin
                        for (int j = 0; j < K_DIM; j++) begin
                            acc += int'(img[(r + i) * IMG_DIM + c + j])
                                 * int'(ker[d * 9 + i * 3 + j]);
                        end
                    end
                    m[d * 36 + r * 6 + c] = clamp_byte(acc >>> SHIFT);
                end
            end
        end
        return m;
    endfunction

    function automatic image_t random_image();
        image_t img;
        for (int i = 0; i < IMG_ENTRIES; i++) begin
            img[i] = pixel_t'($urandom);
        end
        return img;
    endfunction

    function automatic kernel_set_t random_kernels();
        kernel_set_t ker;
        for (int i = 0; i < KER_ENTRIES; i++) begin
            ker[i] = pixel_t'($urandom);
        end
        return ker;
    endfunction

    task automatic queue_image(image_t img);
        load_beat_t b;
        for (int i = 0; i < IMG_ENTRIES; i++) begin
            b.kind = KIND_PIXEL;
            b.data = img[i];
            tx_q.push_back(b);
        end
    endtask

    // weights lo up to hi-1, so a kernel load can be split
    task automatic queue_weights(kernel_set_t ker, int lo, int hi);
        load_beat_t b;
        for (int i = lo; i < hi; i++) begin
            b.kind = KIND_WEIGHT;
            b.data = ker[i];
            tx_q.push_back(b);
        end
    endtask

    // one beat per cycle, no gaps, strobe dropped after the last
    task automatic send_queue();
        load_beat_t b;
        while (tx_q.size() > 0) begin
            b = tx_q.pop_front();
            @(posedge clk);
            beat_valid <= 1'b1;
            beat       <= b;
        end
        @(posedge clk);
        beat_valid <= 1'b0;
    endtask

    task automatic check_fmap(string name, fmap_t exp, fmap_t act);
        int first;
        first = -1;
        for (int i = FMAP_ENTRIES - 1; i >= 0; i--) begin
            if (exp[i] !== act[i]) begin
                first = i;
            end
        end
        if (first >= 0) begin
            $display("Mismatch %s: fmap[%0d] expected %0d actual %0d",
                     name, first, exp[first], act[first]);
            errors++;
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    // valid must rise on the second edge after the last beat was driven
    task automatic check_latency(string name);
        @(negedge clk);
        check_bit({name, " valid one edge after"}, 1'b0, fmap_valid);
        @(negedge clk);
        check_bit({name, " valid two edges after"}, 1'b1, fmap_valid);
    endtask

    task automatic wait_results(string name, int count);
        int waited;
        waited = 0;
        while (res_q.size() < count && waited < RESULT_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (res_q.size() < count) begin
            $display("%s: fmap_valid did not arrive within %0d cycles", name, RESULT_TIMEOUT);
            errors++;
        end
    endtask

    task automatic check_result(string name, fmap_t exp);
        if (res_q.size() == 0) begin
            $display("%s: no result was captured to compare", name);
            errors++;
        end else begin
            check_fmap(name, exp, res_q.pop_front());
        end
    endtask

    task automatic start_test();
        err_mark = errors;
        tests_run++;
    endtask

    task automatic finish_test(string name);
        if (errors == err_mark) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_mark);
        end
    endtask

    task automatic test_reset();
        start_test();
        check_bit("reset fmap_valid", 1'b0, fmap_valid);
        check_fmap("reset fmap", '0, fmap);
        finish_test("reset");
    endtask

    task automatic test_identity();
        kernel_set_t ker;
        image_t      img;
        fmap_t       exp;
        start_test();
        ker = '0;
        for (int d = 0; d < N_KERNELS; d++) begin
            ker[d * 9 + 4] = 8'sd64;
        end
        img = random_image();
        queue_weights(ker, 0, KER_ENTRIES);
        send_queue();
        cur_ker = ker;
        queue_image(img);
        send_queue();
        check_latency("identity");
        wait_results("identity", 1);
        // center tap of 64 then >>8 is the pixel >>2
        for (int d = 0; d < N_KERNELS; d++) begin
            for (int r = 0; r < OUT_DIM; r++) begin
                for (int c = 0; c < OUT_DIM; c++) begin
                    exp[d * 36 + r * 6 + c] = img[(r + 1) * IMG_DIM + c + 1] >>> 2;
                end
            end
        end
        check_result("identity", exp);
        finish_test("identity");
    endtask

    task automatic test_random();
        image_t img;
        start_test();
        cur_ker = random_kernels();
        img = random_image();
        queue_weights(cur_ker, 0, KER_ENTRIES);
        queue_image(img);
        send_queue();
        wait_results("random", 1);
        check_result("random", ref_fmap(img, cur_ker));
        finish_test("random");
    endtask

    task automatic test_saturation();
        image_t img;
        fmap_t  exp;
        start_test();
        img = '{default: 8'sd127};
        cur_ker = '{default: 8'sd127};
        queue_weights(cur_ker, 0, KER_ENTRIES);
        queue_image(img);
        send_queue();
        wait_results("saturation high", 1);
        exp = '{default: 8'sd127};
        check_result("saturation high", exp);
        // negated kernels drive the sum far below the range
        cur_ker = '{default: -8'sd127};
        queue_weights(cur_ker, 0, KER_ENTRIES);
        queue_image(img);
        send_queue();
        wait_results("saturation low", 1);
        exp = '{default: -8'sd128};
        check_result("saturation low", exp);
        finish_test("saturation");
    endtask

    task automatic test_reuse_order();
        image_t      img;
        kernel_set_t ker;
        start_test();
        // old kernels stay in place
        img = random_image();
        queue_image(img);
        send_queue();
        wait_results("reuse", 1);
        check_result("reuse", ref_fmap(img, cur_ker));
        // image completes while a kernel reload is half done
        ker = random_kernels();
        img = random_image();
        queue_weights(ker, 0, 10);
        queue_image(img);
        queue_weights(ker, 10, KER_ENTRIES);
        send_queue();
        cur_ker = ker;
        if (res_q.size() != 0) begin
            $display("order: a result appeared before the last weight was sent");
            errors++;
            res_q.delete();
        end
        check_latency("order");
        wait_results("order", 1);
        check_result("order", ref_fmap(img, cur_ker));
        finish_test("reuse_order");
    endtask

    task automatic test_back_to_back();
        image_t img_a;
        image_t img_b;
        start_test();
        img_a = random_image();
        img_b = random_image();
        queue_image(img_a);
        queue_image(img_b);
        send_queue();
        wait_results("back_to_back", 2);
        // idle long enough for any extra pulse to show up
        repeat (8) @(negedge clk);
        if (res_q.size() > 2) begin
            $display("back_to_back: expected 2 fmap_valid pulses, saw %0d", res_q.size());
            errors++;
        end
        check_result("back_to_back first", ref_fmap(img_a, cur_ker));
        check_result("back_to_back second", ref_fmap(img_b, cur_ker));
        res_q.delete();
        finish_test("back_to_back");
    endtask

    initial begin
        void'($urandom(3176));
        errors       = 0;
        err_mark     = 0;
        tests_run    = 0;
        tests_failed = 0;
        cur_ker      = '0;
        arst_n       = 1'b0;
        beat_valid   = 1'b0;
        beat         = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);

        test_reset();
        test_identity();
        test_random();
        test_saturation();
        test_reuse_order();
        test_back_to_back();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- sim/conv_props.sv
module conv_props (
    input logic            clk,
    input logic            arst_n,
    input logic            start,
    input logic            fmap_valid,
    input conv_pkg::fmap_t fmap
);
    timeunit 1ns;
    timeprecision 100ps;

    // engine registers the map on the edge after start
    a_start_to_valid: assert property (
        @(posedge clk) disable iff (!arst_n)
        start |=> fmap_valid
    ) else $error("start was not followed by fmap_valid");

    // one pulse per result
    a_single_pulse: assert property (
        @(posedge clk) disable iff (!arst_n)
        fmap_valid |=> !fmap_valid
    ) else $error("fmap_valid stayed high for two cycles");

    // presented map fully driven
    a_fmap_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        fmap_valid |-> !$isunknown(fmap)
    ) else $error("fmap holds unknown bits while fmap_valid is high");

endmodule

bind conv_top conv_props i_conv_props (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (start),
    .fmap_valid (fmap_valid),
    .fmap       (fmap)
);

//--- source/conv_top.sv
module conv_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 beat_valid,
    input  conv_pkg::load_beat_t beat,
    output conv_pkg::fmap_t      fmap,
    output logic                 fmap_valid
);
    import conv_pkg::*;

    logic        img_wr;
    logic        ker_wr;
    pixel_t      wr_data;
    logic        img_filled;
    logic        ker_filled;
    logic        start;
    image_t      image;
    kernel_set_t kernels;

    // beat routing and start decision
    stream_loader i_stream_loader (
        .clk        (clk),
        .arst_n     (arst_n),
        .beat_valid (beat_valid),
        .beat       (beat),
        .img_wr     (img_wr),
        .ker_wr     (ker_wr),
        .wr_data    (wr_data),
        .img_filled (img_filled),
        .ker_filled (ker_filled),
        .start      (start)
    );

    // 64-byte image store
    load_buffer #(
        .payload_t (image_t),
        .ENTRIES   (IMG_ENTRIES)
    ) i_img_buffer (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr      (img_wr),
        .wr_data (wr_data),
        .filled  (img_filled),
        .payload (image)
    );

    // 27-byte kernel store, kept across images
    load_buffer #(
        .payload_t (kernel_set_t),
        .ENTRIES   (KER_ENTRIES)
    ) i_ker_buffer (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr      (ker_wr),
        .wr_data (wr_data),
        .filled  (ker_filled),
        .payload (kernels)
    );

    conv_engine i_conv_engine (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .image      (image),
        .kernels    (kernels),
        .fmap       (fmap),
        .fmap_valid (fmap_valid)
    );

endmodule

//--- source/conv_engine.sv
module conv_engine (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  start,
    input  conv_pkg::image_t      image,
    input  conv_pkg::kernel_set_t kernels,
    output conv_pkg::fmap_t       fmap,
    output logic                  fmap_valid
);
    import conv_pkg::*;

    // combinational results of all 108 windows
    fmap_t fmap_next;

    genvar d, r, c;

    generate
        // d is the kernel, r and c the top-left corner of the window
        for (d = 0; d < N_KERNELS; d++) begin : g_chan
            for (r = 0; r < OUT_DIM; r++) begin : g_row
                for (c = 0; c < OUT_DIM; c++) begin : g_col
                    window_t win;
                    window_t ker;

                    // 3x3 patch out of the raster image
                    always_comb begin
                        for (int k = 0; k < WIN_ENTRIES; k++) begin
                            win[k] = image[(r + k / K_DIM) * IMG_DIM + c + k % K_DIM];
                        end
                    end

                    // kernel d is nine consecutive entries
                    assign ker = kernels[d * WIN_ENTRIES +: WIN_ENTRIES];

                    conv_window_mac i_mac (
                        .window (win),
                        .kernel (ker),
                        .result (fmap_next[(d * OUT_DIM + r) * OUT_DIM + c])
                    );
                end
            end
        end
    endgenerate

    // capture the whole map on start
    // result holds until the next start
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fmap       <= '0;
            fmap_valid <= 1'b0;
        end else begin
            fmap_valid <= start;
            if (start) begin
                fmap <= fmap_next;
            end
        end
    end

endmodule

//--- source/conv_window_mac.sv
module conv_window_mac (
    input  conv_pkg::window_t window,
    input  conv_pkg::window_t kernel,
    output conv_pkg::pixel_t  result
);
    import conv_pkg::*;

    // width left after the shift
    localparam int SCALED_W = ACC_W - SHIFT;

    logic signed [PROD_W-1:0] prod [WIN_ENTRIES];
    acc_t                     sum;
    logic signed [SCALED_W-1:0] scaled;

    // nine signed 8x8 products
    always_comb begin
        for (int i = 0; i < WIN_ENTRIES; i++) begin
            prod[i] = PROD_W'($signed(window[i]) * $signed(kernel[i]));
        end
    end

    // sign-extend each product, then sum
    always_comb begin
        sum = '0;
        for (int i = 0; i < WIN_ENTRIES; i++) begin
            sum = sum + ACC_W'(prod[i]);
        end
    end

    // arithmetic shift right by SHIFT
    // upper bits of the sum taken as a signed value
    assign scaled = sum[ACC_W-1:SHIFT];

    // clamp into the signed byte range
    always_comb begin
        if (scaled > 127) begin
            result = 8'sd127;
        end else if (scaled < -128) begin
            result = -8'sd128;
        end else begin
            result = scaled[PIX_W-1:0];
        end
    end

endmodule

//--- source/stream_loader.sv
module stream_loader (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 beat_valid,
    input  conv_pkg::load_beat_t beat,
    output logic                 img_wr,
    output logic                 ker_wr,
    output conv_pkg::pixel_t     wr_data,
    input  logic                 img_filled,
    input  logic                 ker_filled,
    output logic                 start
);
    import conv_pkg::*;

    // a complete kernel set sits in the kernel buffer
    logic weights_ready;
    // a complete image waits for kernels
    logic image_pending;
    // image side of the start condition
    logic img_done;
    // kernel side of the start condition
    logic ker_ok;
    // both sides met this cycle
    logic fire;

    // route by tag, byte goes to both buffers
    assign img_wr  = beat_valid && (beat.kind == KIND_PIXEL);
    assign ker_wr  = beat_valid && (beat.kind == KIND_WEIGHT);
    assign wr_data = beat.data;

    // image completes now or completed earlier
    assign img_done = img_filled || image_pending;

    // kernels complete now or completed earlier
    // a partial reload has cleared weights_ready until its last weight
    assign ker_ok = ker_filled || weights_ready;

    assign fire = img_done && ker_ok;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            weights_ready <= 1'b0;
            image_pending <= 1'b0;
            start         <= 1'b0;
        end else begin
            // one-cycle start, right after the completing beat
            start <= fire;

            // kernels stay valid across images
            // only a new weight stream clears them
            if (ker_filled) begin
                weights_ready <= 1'b1;
            end else if (ker_wr) begin
                weights_ready <= 1'b0;
            end

            // pending image is consumed by the start
            if (fire) begin
                image_pending <= 1'b0;
            end else if (img_filled) begin
                image_pending <= 1'b1;
            end
        end
    end

endmodule

//--- source/load_buffer.sv
module load_buffer #(
    parameter type payload_t = conv_pkg::image_t,
    parameter int  ENTRIES   = conv_pkg::IMG_ENTRIES
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             wr,
    input  conv_pkg::pixel_t wr_data,
    output logic             filled,
    output payload_t         payload
);
    import conv_pkg::*;

    // pointer wide enough for ENTRIES-1
    localparam int PTR_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;
    localparam logic [PTR_W-1:0] LAST = PTR_W'(ENTRIES - 1);

    logic [PTR_W-1:0]      ptr;
    pixel_t [ENTRIES-1:0]  store;

    // write pointer, wraps after the last entry
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr <= '0;
        end else if (wr) begin
            ptr <= (ptr == LAST) ? '0 : ptr + 1'b1;
        end
    end

    // byte storage, contents only meaningful once filled
    always_ff @(posedge clk) begin
        if (wr) begin
            store[ptr] <= wr_data;
        end
    end

    // high in the cycle the last entry is written
    assign filled = wr && (ptr == LAST);

    // whole store viewed as the payload type
    assign payload = payload_t'(store);

endmodule

//--- source/conv_pkg.sv
package conv_pkg;

    // image geometry
    localparam int IMG_DIM = 8;
    localparam int K_DIM = 3;
    // valid convolution, no padding, stride 1
    localparam int OUT_DIM = IMG_DIM - K_DIM + 1;
    // one output channel per kernel
    localparam int N_KERNELS = 3;

    // datapath widths
    localparam int PIX_W = 8;
    // full signed 8x8 product
    localparam int PROD_W = 16;
    // nine products plus growth headroom
    localparam int ACC_W = 20;
    // low accumulator bits dropped before clamping
    localparam int SHIFT = 8;

    // buffer depths in bytes
    localparam int IMG_ENTRIES = IMG_DIM * IMG_DIM;
    localparam int KER_ENTRIES = N_KERNELS * K_DIM * K_DIM;
    localparam int WIN_ENTRIES = K_DIM * K_DIM;
    localparam int FMAP_ENTRIES = N_KERNELS * OUT_DIM * OUT_DIM;

    // signed pixel or weight byte
    typedef logic signed [PIX_W-1:0] pixel_t;

    // signed sum of nine widened products
    typedef logic signed [ACC_W-1:0] acc_t;

    // tag on each incoming byte
    typedef enum logic {
        KIND_PIXEL  = 1'b0,
        KIND_WEIGHT = 1'b1
    } beat_kind_t;

    // one input byte with its tag, 9 bits
    typedef struct packed {
        beat_kind_t kind;
        pixel_t     data;
    } load_beat_t;

    // whole image, entry 0 at row 0 column 0, raster order
    typedef pixel_t [IMG_ENTRIES-1:0] image_t;

    // all kernels
    // entry = kernel*9 + row*3 + col
    typedef pixel_t [KER_ENTRIES-1:0] kernel_set_t;

    // one 3x3 window or one kernel, row-major
    typedef pixel_t [WIN_ENTRIES-1:0] window_t;

    // output feature map
    // entry = channel*36 + row*6 + col
    typedef pixel_t [FMAP_ENTRIES-1:0] fmap_t;

endpackage
